//--- include/rvcpu_cfg.svh
// rvcpu configuration macros
`ifndef RVCPU_CFG_SVH
`define RVCPU_CFG_SVH

// reset pc, also the base of both memories
`define PC_START 64'h0000_0000_8000_0000

// addi x0, x0, 0
`define INST_NOP 32'h0000_0013

// major opcodes of the supported subset
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111
`endif

//--- design/rvcpu_pkg.sv
// rvcpu shared types
`default_nettype none

package rvcpu_pkg;

	typedef logic [63:0] xlen_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [7:0]  byte_en_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	// where an execute operand comes from
	typedef enum logic [1:0] {
		FWD_RF,
		FWD_ME,
		FWD_WB
	} fwd_sel_e;

	typedef struct packed {
		logic  valid;
		xlen_t pc;
		inst_t inst;
	} if_id_t;

	typedef struct packed {
		xlen_t     pc;
		reg_addr_t rs1_addr;
		reg_addr_t rs2_addr;
		xlen_t     rs1_data;
		xlen_t     rs2_data;
		xlen_t     imm;
		alu_op_e   alu_op;
		logic      op2_imm;
		logic      branch;
		logic      branch_ne;
		logic      jump;
		logic      mem_rena;
		logic      mem_wena;
		byte_en_t  byte_en;
		logic      load_un;
		logic      rd_wena;
		reg_addr_t rd_addr;
	} id_ex_t;

	typedef struct packed {
		xlen_t     alu_result;
		xlen_t     store_data;
		logic      mem_rena;
		logic      mem_wena;
		byte_en_t  byte_en;
		logic      load_un;
		logic      rd_wena;
		reg_addr_t rd_addr;
	} ex_me_t;

	typedef struct packed {
		xlen_t     wdata;
		logic      rd_wena;
		reg_addr_t rd_addr;
	} me_wb_t;

endpackage

`default_nettype wire

//--- design/fetch_stage.sv
// instruction fetch stage
`timescale 1ns/1ps
`default_nettype none
`include "rvcpu_cfg.svh"

module fetch_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                stall,
	input  logic                redirect,
	input  rvcpu_pkg::xlen_t    redirect_pc,
	input  rvcpu_pkg::xlen_t    inst_rdata,
	output rvcpu_pkg::xlen_t    inst_addr,
	output logic                inst_ena,
	output rvcpu_pkg::if_id_t   if_id
);

	rvcpu_pkg::xlen_t pc;
	rvcpu_pkg::inst_t inst;

	// word index into the instruction memory
	assign inst_addr = (pc - `PC_START) >> 3;
	// no new fetch needed while the pipe front is held
	assign inst_ena = ~stall;
	// pc bit 2 picks the upper or lower half of the word
	assign inst = pc[2] ? inst_rdata[63:32] : inst_rdata[31:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `PC_START;
			if_id <= '{valid: 1'b0, pc: '0, inst: `INST_NOP};
		end else if (redirect) begin
			pc <= redirect_pc;
			if_id <= '{valid: 1'b0, pc: '0, inst: `INST_NOP};
		end else if (!stall) begin
			pc <= pc + 64'd4;
			if_id <= '{valid: 1'b1, pc: pc, inst: inst};
		end
	end

endmodule

`default_nettype wire

//--- design/decode_stage.sv
// instruction decode stage
`timescale 1ns/1ps
`default_nettype none
`include "rvcpu_cfg.svh"

module decode_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rvcpu_pkg::if_id_t     if_id,
	input  logic                  stall,
	input  logic                  redirect,
	output rvcpu_pkg::reg_addr_t  rs1_addr,
	output rvcpu_pkg::reg_addr_t  rs2_addr,
	output logic                  rs1_used,
	output logic                  rs2_used,
	input  rvcpu_pkg::xlen_t      rs1_data,
	input  rvcpu_pkg::xlen_t      rs2_data,
	output rvcpu_pkg::id_ex_t     id_ex
);

	rvcpu_pkg::inst_t  inst;
	rvcpu_pkg::id_ex_t dec;
	logic [2:0]        funct3;

	assign inst = if_id.inst;
	assign funct3 = inst[14:12];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];

	always_comb begin
		dec = '0;
		rs1_used = 1'b0;
		rs2_used = 1'b0;
		dec.pc = if_id.pc;
		dec.rs1_data = rs1_data;
		dec.rs2_data = rs2_data;
		dec.rd_addr = inst[11:7];
		// sd/ld move a full word, sb/lbu one byte
		dec.byte_en = (funct3[1:0] == 2'b11) ? 8'hff : 8'h01;
		dec.load_un = funct3[2];
		if (if_id.valid) begin
			case (inst[6:0])
				`OPC_OP: begin
					rs1_used = 1'b1;
					rs2_used = 1'b1;
					dec.rd_wena = 1'b1;
					case (funct3)
						3'b111: dec.alu_op = rvcpu_pkg::ALU_AND;
						3'b110: dec.alu_op = rvcpu_pkg::ALU_OR;
						3'b100: dec.alu_op = rvcpu_pkg::ALU_XOR;
						3'b010: dec.alu_op = rvcpu_pkg::ALU_SLT;
						default: dec.alu_op = inst[30] ? rvcpu_pkg::ALU_SUB : rvcpu_pkg::ALU_ADD;
					endcase
				end
				`OPC_OP_IMM, `OPC_LOAD: begin
					rs1_used = 1'b1;
					dec.rd_wena = 1'b1;
					dec.op2_imm = 1'b1;
					dec.mem_rena = (inst[6:0] == `OPC_LOAD);
					dec.imm = {{52{inst[31]}}, inst[31:20]};
				end
				`OPC_LUI: begin
					dec.rd_wena = 1'b1;
					dec.op2_imm = 1'b1;
					dec.alu_op = rvcpu_pkg::ALU_PASS_B;
					dec.imm = {{32{inst[31]}}, inst[31:12], 12'b0};
				end
				`OPC_STORE: begin
					rs1_used = 1'b1;
					rs2_used = 1'b1;
					dec.mem_wena = 1'b1;
					dec.op2_imm = 1'b1;
					dec.imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
				end
				`OPC_BRANCH: begin
					rs1_used = 1'b1;
					rs2_used = 1'b1;
					dec.branch = 1'b1;
					dec.branch_ne = funct3[0];
					dec.imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
				end
				`OPC_JAL: begin
					dec.rd_wena = 1'b1;
					dec.jump = 1'b1;
					dec.imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
				end
				default: ;
			endcase
		end
		// unused sources read as x0 so they never match a forward
		dec.rs1_addr = rs1_used ? rs1_addr : '0;
		dec.rs2_addr = rs2_used ? rs2_addr : '0;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			id_ex <= '0;
		else if (stall || redirect)
			id_ex <= '0;
		else
			id_ex <= dec;
	end

endmodule

`default_nettype wire

//--- design/regfile.sv
// integer register file
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        w_ena,
	input  logic [4:0]  w_addr,
	input  logic [63:0] w_data,
	input  logic [4:0]  r_addr1,
	input  logic [4:0]  r_addr2,
	output logic [63:0] r_data1,
	output logic [63:0] r_data2
);

	// x0 has no storage
	logic [63:0] regs [1:31];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (w_ena && w_addr != 5'd0) begin
			regs[w_addr] <= w_data;
		end
	end

	// writeback in the same cycle is seen by decode
	assign r_data1 = (r_addr1 == 5'd0) ? 64'd0 :
		(w_ena && w_addr == r_addr1) ? w_data : regs[r_addr1];
	assign r_data2 = (r_addr2 == 5'd0) ? 64'd0 :
		(w_ena && w_addr == r_addr2) ? w_data : regs[r_addr2];

endmodule

`default_nettype wire

//--- design/hazard_unit.sv
// load-use stall and operand forwarding
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input  rvcpu_pkg::id_ex_t     id_ex,
	input  rvcpu_pkg::ex_me_t     ex_me,
	input  rvcpu_pkg::me_wb_t     me_wb,
	input  rvcpu_pkg::reg_addr_t  rs1_addr,
	input  rvcpu_pkg::reg_addr_t  rs2_addr,
	input  logic                  rs1_used,
	input  logic                  rs2_used,
	output logic                  stall,
	output rvcpu_pkg::fwd_sel_e   rs1_sel,
	output rvcpu_pkg::fwd_sel_e   rs2_sel
);

	// youngest producer wins, MEM before WB
	function automatic rvcpu_pkg::fwd_sel_e pick(input rvcpu_pkg::reg_addr_t src,
		input rvcpu_pkg::ex_me_t me, input rvcpu_pkg::me_wb_t wb);
		if (src != '0 && me.rd_wena && me.rd_addr == src)
			pick = rvcpu_pkg::FWD_ME;
		else if (src != '0 && wb.rd_wena && wb.rd_addr == src)
			pick = rvcpu_pkg::FWD_WB;
		else
			pick = rvcpu_pkg::FWD_RF;
	endfunction

	// load data is not ready until MEM, hold decode one cycle
	assign stall = id_ex.mem_rena && id_ex.rd_addr != '0 &&
		((rs1_used && rs1_addr == id_ex.rd_addr) || (rs2_used && rs2_addr == id_ex.rd_addr));

	assign rs1_sel = pick(id_ex.rs1_addr, ex_me, me_wb);
	assign rs2_sel = pick(id_ex.rs2_addr, ex_me, me_wb);

endmodule

`default_nettype wire

//--- design/exe_stage.sv
// execute stage with branch resolution
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  rvcpu_pkg::id_ex_t    id_ex,
	input  rvcpu_pkg::fwd_sel_e  rs1_sel,
	input  rvcpu_pkg::fwd_sel_e  rs2_sel,
	input  rvcpu_pkg::xlen_t     me_result,
	input  rvcpu_pkg::xlen_t     wb_result,
	output logic                 redirect,
	output rvcpu_pkg::xlen_t     redirect_pc,
	output rvcpu_pkg::ex_me_t    ex_me
);

	rvcpu_pkg::xlen_t op1;
	rvcpu_pkg::xlen_t rs2_fwd;
	rvcpu_pkg::xlen_t op2;
	rvcpu_pkg::xlen_t alu_out;
	logic             taken;

	function automatic rvcpu_pkg::xlen_t fwd_mux(input rvcpu_pkg::fwd_sel_e sel,
		input rvcpu_pkg::xlen_t rf_val, input rvcpu_pkg::xlen_t me_val,
		input rvcpu_pkg::xlen_t wb_val);
		case (sel)
			rvcpu_pkg::FWD_ME: fwd_mux = me_val;
			rvcpu_pkg::FWD_WB: fwd_mux = wb_val;
			default: fwd_mux = rf_val;
		endcase
	endfunction

	assign op1 = fwd_mux(rs1_sel, id_ex.rs1_data, me_result, wb_result);
	assign rs2_fwd = fwd_mux(rs2_sel, id_ex.rs2_data, me_result, wb_result);
	assign op2 = id_ex.op2_imm ? id_ex.imm : rs2_fwd;

	always_comb begin
		case (id_ex.alu_op)
			rvcpu_pkg::ALU_SUB: alu_out = op1 - op2;
			rvcpu_pkg::ALU_AND: alu_out = op1 & op2;
			rvcpu_pkg::ALU_OR: alu_out = op1 | op2;
			rvcpu_pkg::ALU_XOR: alu_out = op1 ^ op2;
			rvcpu_pkg::ALU_SLT: alu_out = {63'd0, $signed(op1) < $signed(op2)};
			rvcpu_pkg::ALU_PASS_B: alu_out = op2;
			default: alu_out = op1 + op2;
		endcase
	end

	// beq/bne compare the raw register operands
	assign taken = id_ex.branch && ((op1 == rs2_fwd) ^ id_ex.branch_ne);
	assign redirect = taken || id_ex.jump;
	assign redirect_pc = id_ex.pc + id_ex.imm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_me <= '0;
		end else begin
			// jal links pc+4
			ex_me.alu_result <= id_ex.jump ? id_ex.pc + 64'd4 : alu_out;
			ex_me.store_data <= rs2_fwd;
			ex_me.mem_rena <= id_ex.mem_rena;
			ex_me.mem_wena <= id_ex.mem_wena;
			ex_me.byte_en <= id_ex.byte_en;
			ex_me.load_un <= id_ex.load_un;
			ex_me.rd_wena <= id_ex.rd_wena;
			ex_me.rd_addr <= id_ex.rd_addr;
		end
	end

endmodule

`default_nettype wire

//--- design/mem_stage.sv
// data memory access stage
`timescale 1ns/1ps
`default_nettype none
`include "rvcpu_cfg.svh"

module mem_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  rvcpu_pkg::ex_me_t   ex_me,
	input  rvcpu_pkg::xlen_t    mem_rdata,
	output logic                mem_rena,
	output rvcpu_pkg::xlen_t    mem_raddr,
	output logic                mem_wena,
	output rvcpu_pkg::xlen_t    mem_waddr,
	output rvcpu_pkg::xlen_t    mem_wdata,
	output rvcpu_pkg::xlen_t    mem_wmask,
	output rvcpu_pkg::xlen_t    me_result,
	output rvcpu_pkg::me_wb_t   me_wb
);

	logic [5:0]          lane_shift;
	rvcpu_pkg::byte_en_t lanes;
	rvcpu_pkg::xlen_t    rdata_shifted;
	rvcpu_pkg::xlen_t    load_val;

	// byte offset within the word, in bits
	assign lane_shift = {ex_me.alu_result[2:0], 3'b000};

	assign mem_rena = ex_me.mem_rena;
	assign mem_wena = ex_me.mem_wena;
	assign mem_raddr = (ex_me.alu_result - `PC_START) >> 3;
	assign mem_waddr = mem_raddr;
	assign mem_wdata = ex_me.store_data << lane_shift;
	assign lanes = ex_me.byte_en << ex_me.alu_result[2:0];

	// one enable bit per byte becomes eight mask bits
	always_comb begin
		for (int i = 0; i < 8; i++)
			mem_wmask[i*8 +: 8] = {8{lanes[i]}};
	end

	// lbu zero-extends the addressed byte
	assign rdata_shifted = mem_rdata >> lane_shift;
	assign load_val = ex_me.load_un ? {56'd0, rdata_shifted[7:0]} : mem_rdata;

	assign me_result = ex_me.alu_result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			me_wb <= '0;
		end else begin
			me_wb.wdata <= ex_me.mem_rena ? load_val : ex_me.alu_result;
			me_wb.rd_wena <= ex_me.rd_wena;
			me_wb.rd_addr <= ex_me.rd_addr;
		end
	end

endmodule

`default_nettype wire

//--- design/rvcpu.sv
// five-stage rv64 core
`timescale 1ns/1ps
`default_nettype none

module rvcpu (
	input  logic              clk,
	input  logic              rst_n,
	input  rvcpu_pkg::xlen_t  inst_rdata,
	output rvcpu_pkg::xlen_t  inst_addr,
	output logic              inst_ena,
	input  rvcpu_pkg::xlen_t  mem_rdata,
	output rvcpu_pkg::xlen_t  mem_raddr,
	output logic              mem_rena,
	output rvcpu_pkg::xlen_t  mem_wdata,
	output rvcpu_pkg::xlen_t  mem_waddr,
	output rvcpu_pkg::xlen_t  mem_wmask,
	output logic              mem_wena
);

	rvcpu_pkg::if_id_t    if_id;
	rvcpu_pkg::id_ex_t    id_ex;
	rvcpu_pkg::ex_me_t    ex_me;
	rvcpu_pkg::me_wb_t    me_wb;
	rvcpu_pkg::reg_addr_t rs1_addr;
	rvcpu_pkg::reg_addr_t rs2_addr;
	rvcpu_pkg::xlen_t     rs1_data;
	rvcpu_pkg::xlen_t     rs2_data;
	rvcpu_pkg::xlen_t     redirect_pc;
	rvcpu_pkg::xlen_t     me_result;
	rvcpu_pkg::fwd_sel_e  rs1_sel;
	rvcpu_pkg::fwd_sel_e  rs2_sel;
	logic                 rs1_used;
	logic                 rs2_used;
	logic                 stall;
	logic                 redirect;

	fetch_stage i_fetch (.clk(clk), .rst_n(rst_n), .stall(stall), .redirect(redirect),
		.redirect_pc(redirect_pc), .inst_rdata(inst_rdata), .inst_addr(inst_addr),
		.inst_ena(inst_ena), .if_id(if_id));

	decode_stage i_decode (.clk(clk), .rst_n(rst_n), .if_id(if_id), .stall(stall),
		.redirect(redirect), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_used(rs1_used),
		.rs2_used(rs2_used), .rs1_data(rs1_data), .rs2_data(rs2_data), .id_ex(id_ex));

	regfile i_regfile (.clk(clk), .rst_n(rst_n), .w_ena(me_wb.rd_wena), .w_addr(me_wb.rd_addr),
		.w_data(me_wb.wdata), .r_addr1(rs1_addr), .r_addr2(rs2_addr), .r_data1(rs1_data),
		.r_data2(rs2_data));

	hazard_unit i_hazard (.id_ex(id_ex), .ex_me(ex_me), .me_wb(me_wb), .rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr), .rs1_used(rs1_used), .rs2_used(rs2_used), .stall(stall),
		.rs1_sel(rs1_sel), .rs2_sel(rs2_sel));

	exe_stage i_exe (.clk(clk), .rst_n(rst_n), .id_ex(id_ex), .rs1_sel(rs1_sel),
		.rs2_sel(rs2_sel), .me_result(me_result), .wb_result(me_wb.wdata),
		.redirect(redirect), .redirect_pc(redirect_pc), .ex_me(ex_me));

	mem_stage i_mem (.clk(clk), .rst_n(rst_n), .ex_me(ex_me), .mem_rdata(mem_rdata),
		.mem_rena(mem_rena), .mem_raddr(mem_raddr), .mem_wena(mem_wena),
		.mem_waddr(mem_waddr), .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
		.me_result(me_result), .me_wb(me_wb));

endmodule

`default_nettype wire

//--- verif/rvcpu_properties.sv
// rvcpu port assertions
`timescale 1ns/1ps
`default_nettype none

module rvcpu_properties (
	input logic             clk,
	input logic             rst_n,
	input rvcpu_pkg::xlen_t inst_addr,
	input logic             mem_rena,
	input logic             mem_wena,
	input logic             redirect
);

	// one data access per cycle
	a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_rena && mem_wena))
		else $error("data port read and write enabled in the same cycle");

	a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !mem_rena && !mem_wena)
		else $error("data port enabled while reset is held");

	// fetch holds or steps one word unless the previous cycle redirected
	a_fetch_seq: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(redirect) |->
		(inst_addr == $past(inst_addr) || inst_addr == $past(inst_addr) + 64'd1))
		else $error("instruction address left the sequential pc order");

endmodule

bind rvcpu rvcpu_properties i_props (
	.clk(clk),
	.rst_n(rst_n),
	.inst_addr(inst_addr),
	.mem_rena(mem_rena),
	.mem_wena(mem_wena),
	.redirect(redirect)
);

`default_nettype wire

//--- verif/tb_rvcpu.sv
// rvcpu directed testbench
`timescale 1ns/1ps
`default_nettype none
`include "rvcpu_cfg.svh"

module tb_rvcpu;

	localparam int DEPTH = 1024;
	// word index of byte address 0x8000_1000
	localparam int DBASE = 512;
	localparam int RESET_CYCLES = 16;
	localparam int RUN_CYCLES = 200;
	localparam int NUM_TESTS = 5;
	localparam int WATCHDOG_NS = NUM_TESTS * 220 * 4 + 600;

	logic             clk;
	logic             rst_n;
	rvcpu_pkg::xlen_t inst_rdata;
	rvcpu_pkg::xlen_t inst_addr;
	logic             inst_ena;
	rvcpu_pkg::xlen_t mem_rdata;
	rvcpu_pkg::xlen_t mem_raddr;
	logic             mem_rena;
	rvcpu_pkg::xlen_t mem_wdata;
	rvcpu_pkg::xlen_t mem_waddr;
	rvcpu_pkg::xlen_t mem_wmask;
	logic             mem_wena;

	rvcpu_pkg::xlen_t mem [DEPTH];
	// image copied into mem while reset is held
	rvcpu_pkg::xlen_t img [DEPTH];
	int               wr_count;
	int               n_inst;
	int               errors;
	int               checks;

	rvcpu i_dut (
		.clk(clk), .rst_n(rst_n),
		.inst_rdata(inst_rdata), .inst_addr(inst_addr), .inst_ena(inst_ena),
		.mem_rdata(mem_rdata), .mem_raddr(mem_raddr), .mem_rena(mem_rena),
		.mem_wdata(mem_wdata), .mem_waddr(mem_waddr), .mem_wmask(mem_wmask),
		.mem_wena(mem_wena)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// shared memory, both ports answer in the same cycle
	assign inst_rdata = inst_ena ? mem[inst_addr[9:0]] : '0;
	assign mem_rdata = mem_rena ? mem[mem_raddr[9:0]] : '0;

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++)
				mem[i[9:0]] <= img[i[9:0]];
		end else if (mem_wena) begin
			mem[mem_waddr[9:0]] <= (mem[mem_waddr[9:0]] & ~mem_wmask) | (mem_wdata & mem_wmask);
		end
	end

	// data-port write monitor
	always @(posedge clk) begin
		if (!rst_n)
			wr_count <= 0;
		else if (mem_wena)
			wr_count <= wr_count + 1;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("*** FAILED ***");
		$finish;
	end

	// rv64 instruction encoders
	function automatic rvcpu_pkg::inst_t r_type(input logic [6:0] f7, input logic [2:0] f3,
		input int rd, input int rs1, input int rs2);
		r_type = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
	endfunction

	function automatic rvcpu_pkg::inst_t i_type(input logic [6:0] opc, input logic [2:0] f3,
		input int rd, input int rs1, input int imm);
		i_type = {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic rvcpu_pkg::inst_t s_type(input logic [2:0] f3, input int rs1,
		input int rs2, input int imm);
		s_type = {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], `OPC_STORE};
	endfunction

	function automatic rvcpu_pkg::inst_t b_type(input logic [2:0] f3, input int rs1,
		input int rs2, input int imm);
		b_type = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], `OPC_BRANCH};
	endfunction

	function automatic rvcpu_pkg::inst_t lui(input int rd, input int imm20);
		lui = {imm20[19:0], rd[4:0], `OPC_LUI};
	endfunction

	function automatic rvcpu_pkg::inst_t j_type(input int rd, input int imm);
		j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `OPC_JAL};
	endfunction

	function automatic rvcpu_pkg::xlen_t sext12(input int v);
		sext12 = {{52{v[11]}}, v[11:0]};
	endfunction

	// background contents, unique per word
	function automatic rvcpu_pkg::xlen_t fill_word(input int idx);
		fill_word = {idx[31:0] ^ 32'h6a09_e667, ~idx[31:0] * 32'h0001_0003};
	endfunction

	task automatic new_image();
		for (int i = 0; i < DEPTH; i++)
			img[i[9:0]] = fill_word(i);
		n_inst = 0;
	endtask

	task automatic emit(input rvcpu_pkg::inst_t inst);
		int w;
		w = n_inst / 2;
		if (n_inst % 2 == 1)
			img[w[9:0]][63:32] = inst;
		else
			img[w[9:0]][31:0] = inst;
		n_inst++;
	endtask

	task automatic run_program();
		@(posedge clk);
		#0.5 rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#0.5 rst_n = 1'b1;
		repeat (RUN_CYCLES) @(posedge clk);
		#0.5;
	endtask

	task automatic check_word(input int idx, input rvcpu_pkg::xlen_t expected, input string what);
		checks++;
		assert (mem[idx[9:0]] === expected) else begin
			errors++;
			$display("FAIL @%0t: %s, word %0d expected %h observed %h",
				$time, what, idx, expected, mem[idx[9:0]]);
		end
	endtask

	task automatic check_writes(input int expected, input string what);
		checks++;
		assert (wr_count == expected) else begin
			errors++;
			$display("FAIL @%0t: %s, expected %0d data writes observed %0d",
				$time, what, expected, wr_count);
		end
	endtask

	task automatic arith_test();
		rvcpu_pkg::xlen_t a;
		rvcpu_pkg::xlen_t b;
		int               imm;
		int               upper;
		a = {$urandom, $urandom};
		b = {$urandom, $urandom};
		imm = $urandom_range(0, 4095);
		upper = $urandom_range(0, 32'h000f_ffff);
		new_image();
		img[DBASE] = a;
		img[DBASE + 1] = b;
		emit(lui(1, 32'h80001));
		emit(i_type(`OPC_LOAD, 3'b011, 2, 1, 0));
		emit(i_type(`OPC_LOAD, 3'b011, 3, 1, 8));
		emit(r_type(7'h00, 3'b000, 4, 2, 3));
		emit(r_type(7'h20, 3'b000, 5, 2, 3));
		emit(r_type(7'h00, 3'b111, 6, 2, 3));
		emit(r_type(7'h00, 3'b110, 7, 2, 3));
		emit(r_type(7'h00, 3'b100, 8, 2, 3));
		emit(r_type(7'h00, 3'b010, 9, 2, 3));
		emit(i_type(`OPC_OP_IMM, 3'b000, 10, 2, imm));
		emit(lui(11, upper));
		emit(r_type(7'h00, 3'b010, 12, 3, 2));
		for (int k = 0; k < 9; k++)
			emit(s_type(3'b011, 1, 4 + k, 16 + 8 * k));
		emit(j_type(0, 0));
		run_program();
		check_word(DBASE + 2, a + b, "add");
		check_word(DBASE + 3, a - b, "sub");
		check_word(DBASE + 4, a & b, "and");
		check_word(DBASE + 5, a | b, "or");
		check_word(DBASE + 6, a ^ b, "xor");
		check_word(DBASE + 7, {63'd0, $signed(a) < $signed(b)}, "slt");
		check_word(DBASE + 8, a + sext12(imm), "addi");
		check_word(DBASE + 9, {{32{upper[19]}}, upper[19:0], 12'h000}, "lui");
		check_word(DBASE + 10, {63'd0, $signed(b) < $signed(a)}, "slt swapped");
		check_writes(9, "arithmetic stores");
	endtask

	task automatic forwarding_test();
		rvcpu_pkg::xlen_t a;
		rvcpu_pkg::xlen_t b;
		rvcpu_pkg::xlen_t r4;
		rvcpu_pkg::xlen_t r5;
		rvcpu_pkg::xlen_t r6;
		rvcpu_pkg::xlen_t r7;
		rvcpu_pkg::xlen_t r8;
		rvcpu_pkg::xlen_t r10;
		int               imm;
		int               imm2;
		a = {$urandom, $urandom};
		b = {$urandom, $urandom};
		imm = $urandom_range(0, 4095);
		imm2 = $urandom_range(0, 4095);
		new_image();
		img[DBASE] = a;
		img[DBASE + 1] = b;
		emit(lui(1, 32'h80001));
		emit(i_type(`OPC_LOAD, 3'b011, 2, 1, 0));
		emit(i_type(`OPC_LOAD, 3'b011, 3, 1, 8));
		// let the loads retire so only alu forwarding is exercised
		emit(`INST_NOP);
		emit(`INST_NOP);
		emit(r_type(7'h00, 3'b000, 4, 2, 3));
		emit(r_type(7'h20, 3'b000, 5, 4, 2));
		emit(r_type(7'h00, 3'b100, 6, 5, 4));
		emit(i_type(`OPC_OP_IMM, 3'b000, 7, 6, imm));
		emit(r_type(7'h00, 3'b110, 8, 7, 5));
		emit(r_type(7'h00, 3'b000, 9, 2, 3));
		emit(i_type(`OPC_OP_IMM, 3'b000, 12, 0, imm2));
		emit(r_type(7'h20, 3'b000, 10, 9, 12));
		emit(r_type(7'h00, 3'b111, 11, 10, 10));
		for (int k = 0; k < 8; k++)
			emit(s_type(3'b011, 1, 4 + k, 16 + 8 * k));
		emit(j_type(0, 0));
		run_program();
		r4 = a + b;
		r5 = r4 - a;
		r6 = r5 ^ r4;
		r7 = r6 + sext12(imm);
		r8 = r7 | r5;
		r10 = (a + b) - sext12(imm2);
		check_word(DBASE + 2, r4, "fwd add");
		check_word(DBASE + 3, r5, "fwd sub distance 1");
		check_word(DBASE + 4, r6, "fwd xor distance 1 and 2");
		check_word(DBASE + 5, r7, "fwd addi");
		check_word(DBASE + 6, r8, "fwd or");
		check_word(DBASE + 7, a + b, "fwd add from regfile");
		check_word(DBASE + 8, r10, "fwd sub distance 2");
		check_word(DBASE + 9, r10, "fwd and same source");
		check_writes(8, "forwarding stores");
	endtask

	task automatic load_use_test();
		rvcpu_pkg::xlen_t a;
		rvcpu_pkg::xlen_t b;
		a = {$urandom, $urandom};
		b = {$urandom, $urandom};
		new_image();
		img[DBASE] = a;
		img[DBASE + 1] = b;
		emit(lui(1, 32'h80001));
		emit(i_type(`OPC_LOAD, 3'b011, 2, 1, 0));
		emit(i_type(`OPC_LOAD, 3'b011, 3, 1, 8));
		emit(r_type(7'h00, 3'b000, 4, 3, 2));
		emit(s_type(3'b011, 1, 4, 16));
		emit(i_type(`OPC_LOAD, 3'b011, 5, 1, 8));
		emit(s_type(3'b011, 1, 5, 24));
		// reload the sum written two stores back
		emit(i_type(`OPC_LOAD, 3'b011, 6, 1, 16));
		emit(i_type(`OPC_OP_IMM, 3'b000, 7, 6, 1));
		emit(s_type(3'b011, 1, 7, 32));
		emit(j_type(0, 0));
		run_program();
		check_word(DBASE + 2, a + b, "load-use add");
		check_word(DBASE + 3, b, "load-use store data");
		check_word(DBASE + 4, a + b + 64'd1, "load-use addi");
		check_writes(3, "load-use stores");
	endtask

	task automatic byte_lane_test();
		rvcpu_pkg::xlen_t r;
		rvcpu_pkg::xlen_t w;
		rvcpu_pkg::xlen_t w3;
		rvcpu_pkg::xlen_t sum;
		r = {$urandom, $urandom};
		// keep every stored byte above 0x7f
		r[7:4] = 4'hc;
		w3 = '0;
		new_image();
		img[DBASE + 32] = r;
		emit(lui(1, 32'h80001));
		emit(i_type(`OPC_LOAD, 3'b011, 5, 1, 256));
		for (int i = 0; i < 8; i++) begin
			emit(i_type(`OPC_OP_IMM, 3'b000, 2, 5, i));
			emit(s_type(3'b000, 1, 2, 9 * i));
		end
		for (int i = 0; i < 8; i++) begin
			emit(i_type(`OPC_LOAD, 3'b100, 3, 1, 9 * i));
			emit(s_type(3'b011, 1, 3, 64 + 8 * i));
		end
		emit(i_type(`OPC_LOAD, 3'b011, 4, 1, 24));
		emit(s_type(3'b011, 1, 4, 128));
		// untouched lane 5 of word 2
		emit(i_type(`OPC_LOAD, 3'b100, 6, 1, 21));
		emit(s_type(3'b011, 1, 6, 136));
		emit(j_type(0, 0));
		run_program();
		for (int i = 0; i < 8; i++) begin
			sum = r + 64'(i);
			w = fill_word(DBASE + i);
			w = (w & ~(64'hff << (8 * i))) | ({56'd0, sum[7:0]} << (8 * i));
			if (i == 3)
				w3 = w;
			check_word(DBASE + i, w, "sb lane");
			check_word(DBASE + 8 + i, {56'd0, sum[7:0]}, "lbu lane");
		end
		w = fill_word(DBASE + 2);
		check_word(DBASE + 16, w3, "ld after sb");
		check_word(DBASE + 17, {56'd0, w[47:40]}, "lbu untouched lane");
		check_writes(18, "byte access stores");
	endtask

	task automatic control_flow_test();
		new_image();
		emit(lui(1, 32'h80001));
		emit(i_type(`OPC_OP_IMM, 3'b000, 2, 0, 7));
		emit(i_type(`OPC_OP_IMM, 3'b000, 3, 0, 7));
		emit(b_type(3'b000, 2, 3, 12));
		emit(s_type(3'b011, 1, 2, 0));
		emit(s_type(3'b011, 1, 2, 8));
		emit(b_type(3'b001, 2, 3, 12));
		emit(s_type(3'b011, 1, 2, 16));
		emit(i_type(`OPC_OP_IMM, 3'b000, 4, 0, 9));
		emit(b_type(3'b001, 2, 4, 12));
		emit(s_type(3'b011, 1, 2, 24));
		emit(s_type(3'b011, 1, 2, 32));
		emit(b_type(3'b000, 2, 4, 12));
		emit(s_type(3'b011, 1, 4, 40));
		// jal at instruction 14 links to the one after it
		emit(j_type(5, 12));
		emit(s_type(3'b011, 1, 2, 48));
		emit(s_type(3'b011, 1, 2, 56));
		emit(s_type(3'b011, 1, 5, 64));
		emit(j_type(0, 0));
		run_program();
		check_word(DBASE + 0, fill_word(DBASE + 0), "beq taken slot 1");
		check_word(DBASE + 1, fill_word(DBASE + 1), "beq taken slot 2");
		check_word(DBASE + 2, 64'd7, "bne not taken");
		check_word(DBASE + 3, fill_word(DBASE + 3), "bne taken slot 1");
		check_word(DBASE + 4, fill_word(DBASE + 4), "bne taken slot 2");
		check_word(DBASE + 5, 64'd9, "beq not taken");
		check_word(DBASE + 6, fill_word(DBASE + 6), "jal slot 1");
		check_word(DBASE + 7, fill_word(DBASE + 7), "jal slot 2");
		check_word(DBASE + 8, `PC_START + 64'd60, "jal link");
		check_writes(3, "control flow stores");
	endtask

	initial begin
		void'($urandom(32'h4cc9));
		errors = 0;
		checks = 0;
		n_inst = 0;
		rst_n = 1'b1;
		#1 rst_n = 1'b0;
		arith_test();
		forwarding_test();
		load_use_test();
		byte_lane_test();
		control_flow_test();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
design/rvcpu_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/regfile.sv
design/hazard_unit.sv
design/exe_stage.sv
design/mem_stage.sv
design/rvcpu.sv
verif/rvcpu_properties.sv
verif/tb_rvcpu.sv

//--- Makefile
# Verilator build and run for the rvcpu testbench

VERILATOR ?= verilator
TOP       ?= tb_rvcpu
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard design/*.sv verif/*.sv include/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '*** FAILED ***' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
